/* vga_pkg.sv */
// Shared types and constants for the VGA display pipeline and the sprite ROM path
// Referenced by scoped names from every design module
`default_nettype none

package vga_pkg;

    // 4 bits per channel with red in the top nibble
    typedef logic [11:0] rgb_t;

    typedef logic [12:0] rom_addr_t;

    typedef enum logic {
        REQ_DOG = 1'b0,
        REQ_CAT = 1'b1
    } requester_e;

    // Pixel bus passed from stage to stage
    typedef struct packed {
        logic [10:0] hcount;
        logic [10:0] vcount;
        logic        hsync;
        logic        vsync;
        logic        hblnk;
        logic        vblnk;
        rgb_t        rgb;
    } vga_bus_t;

    typedef struct packed {
        rom_addr_t  addr;
        requester_e id;
    } rom_req_t;

    // Column travels with the data so the drawer needs no reorder logic
    typedef struct packed {
        rgb_t       pixel;
        requester_e id;
        logic [4:0] col;
    } rom_rsp_t;

    localparam rgb_t SKY_RGB         = 12'h6AF;
    localparam rgb_t GROUND_RGB      = 12'h462;
    localparam rgb_t TRANSPARENT_RGB = 12'hF0F;

    localparam int SPRITE_W    = 32;
    localparam int SPRITE_H    = 32;
    localparam int GROUND_ROWS = 16;

    // Reset value of the bus with inactive syncs and blanking set
    localparam vga_bus_t VGA_IDLE = '{
        hcount: '0,
        vcount: '0,
        hsync:  1'b1,
        vsync:  1'b1,
        hblnk:  1'b1,
        vblnk:  1'b1,
        rgb:    '0
    };

endpackage

`default_nettype wire

/* vga_timing.sv */
// Pixel and line counters with blanking and sync for one video mode
// Mode numbers come from the top level; output is fully registered
`timescale 1ns/1ps
`default_nettype none

module vga_timing #(
    parameter int H_ACTIVE = 1024,
    parameter int H_FP     = 24,
    parameter int H_SYNC   = 136,
    parameter int H_BP     = 160,
    parameter int V_ACTIVE = 768,
    parameter int V_FP     = 3,
    parameter int V_SYNC   = 6,
    parameter int V_BP     = 29
) (
    input  logic              clk,
    input  logic              arst_n,
    output vga_pkg::vga_bus_t vga_out
);

    localparam int H_TOTAL  = H_ACTIVE + H_FP + H_SYNC + H_BP;
    localparam int V_TOTAL  = V_ACTIVE + V_FP + V_SYNC + V_BP;
    localparam int HS_START = H_ACTIVE + H_FP;
    localparam int VS_START = V_ACTIVE + V_FP;

    logic [10:0] h_cnt;
    logic [10:0] v_cnt;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            h_cnt <= '0;
            v_cnt <= '0;
        end else if (h_cnt == 11'(H_TOTAL - 1)) begin
            h_cnt <= '0;
            if (v_cnt == 11'(V_TOTAL - 1)) begin
                v_cnt <= '0;
            end else begin
                v_cnt <= v_cnt + 1'b1;
            end
        end else begin
            h_cnt <= h_cnt + 1'b1;
        end
    end

    // Syncs are active low
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            vga_out <= vga_pkg::VGA_IDLE;
        end else begin
            vga_out.hcount <= h_cnt;
            vga_out.vcount <= v_cnt;
            vga_out.hblnk  <= (h_cnt >= 11'(H_ACTIVE));
            vga_out.vblnk  <= (v_cnt >= 11'(V_ACTIVE));
            vga_out.hsync  <= !((h_cnt >= 11'(HS_START)) && (h_cnt < 11'(HS_START + H_SYNC)));
            vga_out.vsync  <= !((v_cnt >= 11'(VS_START)) && (v_cnt < 11'(VS_START + V_SYNC)));
            vga_out.rgb    <= '0;
        end
    end

endmodule

`default_nettype wire

/* draw_bg.sv */
// Background stage: sky above a ground strip, black in blanking
`timescale 1ns/1ps
`default_nettype none

module draw_bg #(
    parameter int V_ACTIVE = 768
) (
    input  logic              clk,
    input  logic              arst_n,
    input  vga_pkg::vga_bus_t vga_in,
    output vga_pkg::vga_bus_t vga_out
);

    // First line of the ground strip
    localparam logic [10:0] GROUND_TOP = 11'(V_ACTIVE - vga_pkg::GROUND_ROWS);

    vga_pkg::rgb_t bg_rgb;

    always_comb begin
        if (vga_in.hblnk || vga_in.vblnk) begin
            bg_rgb = '0;
        end else if (vga_in.vcount >= GROUND_TOP) begin
            bg_rgb = vga_pkg::GROUND_RGB;
        end else begin
            bg_rgb = vga_pkg::SKY_RGB;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            vga_out <= vga_pkg::VGA_IDLE;
        end else begin
            vga_out     <= vga_in;
            vga_out.rgb <= bg_rgb;
        end
    end

endmodule

`default_nettype wire

/* sprite_rom.sv */
// Sprite image memory for both players, one registered read port
// Dog rows sit at 0..1023, cat rows at 1024..2047
`timescale 1ns/1ps
`default_nettype none

module sprite_rom (
    input  logic              clk,
    input  logic              arst_n,
    input  vga_pkg::rom_req_t rom_req,
    input  logic              rom_req_valid,
    output vga_pkg::rom_rsp_t rom_rsp,
    output logic              rom_rsp_valid
);

    localparam int ROM_DEPTH = 2 * vga_pkg::SPRITE_W * vga_pkg::SPRITE_H;
    localparam int AW        = $clog2(ROM_DEPTH);
    localparam int COL_W     = $clog2(vga_pkg::SPRITE_W);

    vga_pkg::rgb_t mem [ROM_DEPTH];

    // Colour is a fixed mix of address bits
    function automatic vga_pkg::rgb_t rom_word(input logic [10:0] a);
        return {a[3:0], a[7:4], a[10], a[10:8]};
    endfunction

    initial begin
        for (int i = 0; i < ROM_DEPTH; i++) begin
            mem[i] = rom_word(11'(i));
        end
    end

    always_ff @(posedge clk) begin
        rom_rsp.pixel <= mem[rom_req.addr[AW-1:0]];
        rom_rsp.id    <= rom_req.id;
        rom_rsp.col   <= rom_req.addr[COL_W-1:0];
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rom_rsp_valid <= 1'b0;
        end else begin
            rom_rsp_valid <= rom_req_valid;
        end
    end

endmodule

`default_nettype wire

/* sprite_rom_arbiter.sv */
// Round-robin sharing of the sprite ROM between the dog and cat drawers
// Responses return to the requester named in their id
`timescale 1ns/1ps
`default_nettype none

module sprite_rom_arbiter (
    input  logic              clk,
    input  logic              arst_n,

    input  vga_pkg::rom_req_t dog_req,
    input  logic              dog_req_valid,
    output logic              dog_req_ready,

    input  vga_pkg::rom_req_t cat_req,
    input  logic              cat_req_valid,
    output logic              cat_req_ready,

    output vga_pkg::rom_req_t rom_req,
    output logic              rom_req_valid,

    input  vga_pkg::rom_rsp_t rom_rsp,
    input  logic              rom_rsp_valid,

    output vga_pkg::rom_rsp_t dog_rsp,
    output logic              dog_rsp_valid,
    output vga_pkg::rom_rsp_t cat_rsp,
    output logic              cat_rsp_valid
);

    vga_pkg::requester_e last_grant;
    logic                grant_cat;

    // On a tie the side that lost last time wins
    always_comb begin
        if (dog_req_valid && cat_req_valid) begin
            grant_cat = (last_grant == vga_pkg::REQ_DOG);
        end else begin
            grant_cat = cat_req_valid;
        end
    end

    // ROM takes a request every cycle
    assign dog_req_ready = dog_req_valid && !grant_cat;
    assign cat_req_ready = cat_req_valid && grant_cat;
    assign rom_req       = grant_cat ? cat_req : dog_req;
    assign rom_req_valid = dog_req_valid || cat_req_valid;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            last_grant <= vga_pkg::REQ_CAT;
        end else if (rom_req_valid) begin
            last_grant <= grant_cat ? vga_pkg::REQ_CAT : vga_pkg::REQ_DOG;
        end
    end

    // Data goes to both drawers and only the valid is steered
    assign dog_rsp       = rom_rsp;
    assign cat_rsp       = rom_rsp;
    assign dog_rsp_valid = rom_rsp_valid && (rom_rsp.id == vga_pkg::REQ_DOG);
    assign cat_rsp_valid = rom_rsp_valid && (rom_rsp.id == vga_pkg::REQ_CAT);

    a_one_grant: assert property (
        @(posedge clk) disable iff (!arst_n) !(dog_req_ready && cat_req_ready)
    );

    // A requester held off in one cycle is served in the next
    a_no_starve_dog: assert property (
        @(posedge clk) disable iff (!arst_n)
        dog_req_valid && !dog_req_ready |=> !dog_req_valid || dog_req_ready
    );

    a_no_starve_cat: assert property (
        @(posedge clk) disable iff (!arst_n)
        cat_req_valid && !cat_req_ready |=> !cat_req_valid || cat_req_ready
    );

endmodule

`default_nettype wire

/* draw_player.sv */
// Sprite drawer: prefetches the next line's row into a line buffer during
// horizontal blanking, then overlays opaque pixels on the passing bus
`timescale 1ns/1ps
`default_nettype none

module draw_player #(
    parameter int ROM_BASE = 0,
    parameter int V_TOTAL  = 806
) (
    input  logic              clk,
    input  logic              arst_n,
    input  logic [10:0]       x_pos,
    input  logic [10:0]       y_pos,
    input  vga_pkg::vga_bus_t vga_in,
    output vga_pkg::vga_bus_t vga_out,
    output vga_pkg::rom_req_t req,
    output logic              req_valid,
    input  logic              req_ready,
    input  vga_pkg::rom_rsp_t rsp,
    input  logic              rsp_valid
);

    localparam int COL_W = $clog2(vga_pkg::SPRITE_W);
    localparam int ROW_W = $clog2(vga_pkg::SPRITE_H);

    // Each sprite owns one slot of SPRITE_W*SPRITE_H words
    localparam vga_pkg::requester_e REQ_ID =
        vga_pkg::requester_e'(ROM_BASE / (vga_pkg::SPRITE_W * vga_pkg::SPRITE_H));

    vga_pkg::rgb_t    line_buf [vga_pkg::SPRITE_W];
    vga_pkg::rgb_t    sprite_rgb;
    logic [10:0]      next_line;
    logic [10:0]      fetch_row;
    logic [10:0]      pix_col;
    logic             hblnk_start;
    logic             row_hit;
    logic             col_hit;
    logic             line_hit;
    logic             fetch_active;
    logic [ROW_W-1:0] row_sel;
    logic [COL_W-1:0] req_col;
    logic [COL_W:0]   rsp_cnt;

    assign next_line = (vga_in.vcount == 11'(V_TOTAL - 1)) ? '0 : vga_in.vcount + 1'b1;
    assign fetch_row = next_line - y_pos;
    assign row_hit   = (next_line >= y_pos) && (fetch_row < 11'(vga_pkg::SPRITE_H));

    // vga_out still holds last cycle's hblnk
    assign hblnk_start = vga_in.hblnk && !vga_out.hblnk;

    assign req.addr = vga_pkg::rom_addr_t'(ROM_BASE) + vga_pkg::rom_addr_t'({row_sel, req_col});
    assign req.id   = REQ_ID;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            line_hit     <= 1'b0;
            fetch_active <= 1'b0;
            req_valid    <= 1'b0;
            req_col      <= '0;
            row_sel      <= '0;
            rsp_cnt      <= '0;
        end else if (hblnk_start) begin
            line_hit     <= row_hit;
            fetch_active <= row_hit;
            req_valid    <= row_hit;
            req_col      <= '0;
            row_sel      <= fetch_row[ROW_W-1:0];
            rsp_cnt      <= '0;
        end else begin
            if (req_valid && req_ready) begin
                if (req_col == COL_W'(vga_pkg::SPRITE_W - 1)) begin
                    req_valid <= 1'b0;
                end
                req_col <= req_col + 1'b1;
            end
            // Done once every column has come back
            if (rsp_valid) begin
                rsp_cnt <= rsp_cnt + 1'b1;
                if (rsp_cnt == (COL_W + 1)'(vga_pkg::SPRITE_W - 1)) begin
                    fetch_active <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rsp_valid) begin
            line_buf[rsp.col] <= rsp.pixel;
        end
    end

    assign pix_col    = vga_in.hcount - x_pos;
    assign col_hit    = (vga_in.hcount >= x_pos) && (pix_col < 11'(vga_pkg::SPRITE_W));
    assign sprite_rgb = line_buf[pix_col[COL_W-1:0]];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            vga_out <= vga_pkg::VGA_IDLE;
        end else begin
            vga_out <= vga_in;
            if (!vga_in.hblnk && !vga_in.vblnk && line_hit && col_hit &&
                (sprite_rgb != vga_pkg::TRANSPARENT_RGB)) begin
                vga_out.rgb <= sprite_rgb;
            end
        end
    end

    a_req_stable: assert property (
        @(posedge clk) disable iff (!arst_n)
        req_valid && !req_ready |=> req_valid && $stable(req)
    );

    // Line buffer must be complete before the first active pixel
    a_fetch_in_blank: assert property (
        @(posedge clk) disable iff (!arst_n) $fell(vga_in.hblnk) |-> !fetch_active
    );

endmodule

`default_nettype wire

/* top_vga.sv */
// Display top level: timing, background, dog and cat sprites over a shared ROM
// Sprite positions are inputs; the cat layer sits above the dog
`timescale 1ns/1ps
`default_nettype none

module top_vga #(
    parameter int H_ACTIVE = 1024,
    parameter int H_FP     = 24,
    parameter int H_SYNC   = 136,
    parameter int H_BP     = 160,
    parameter int V_ACTIVE = 768,
    parameter int V_FP     = 3,
    parameter int V_SYNC   = 6,
    parameter int V_BP     = 29
) (
    input  logic        clk,
    input  logic        arst_n,
    input  logic [10:0] dog_x,
    input  logic [10:0] dog_y,
    input  logic [10:0] cat_x,
    input  logic [10:0] cat_y,
    output logic        hs,
    output logic        vs,
    output logic [3:0]  r,
    output logic [3:0]  g,
    output logic [3:0]  b
);

    // Pixel bus between stages
    vga_pkg::vga_bus_t vga_tim;
    vga_pkg::vga_bus_t vga_bg;
    vga_pkg::vga_bus_t vga_dog;
    vga_pkg::vga_bus_t vga_cat;

    // Sprite ROM traffic
    vga_pkg::rom_req_t dog_req;
    vga_pkg::rom_req_t cat_req;
    vga_pkg::rom_req_t rom_req;
    vga_pkg::rom_rsp_t dog_rsp;
    vga_pkg::rom_rsp_t cat_rsp;
    vga_pkg::rom_rsp_t rom_rsp;
    logic              dog_req_valid;
    logic              dog_req_ready;
    logic              cat_req_valid;
    logic              cat_req_ready;
    logic              rom_req_valid;
    logic              dog_rsp_valid;
    logic              cat_rsp_valid;
    logic              rom_rsp_valid;

    assign hs        = vga_cat.hsync;
    assign vs        = vga_cat.vsync;
    assign {r, g, b} = vga_cat.rgb;

    vga_timing #(
        .H_ACTIVE (H_ACTIVE), .H_FP (H_FP), .H_SYNC (H_SYNC), .H_BP (H_BP),
        .V_ACTIVE (V_ACTIVE), .V_FP (V_FP), .V_SYNC (V_SYNC), .V_BP (V_BP)
    ) u_vga_timing (
        .clk     (clk),
        .arst_n  (arst_n),
        .vga_out (vga_tim)
    );

    draw_bg #(
        .V_ACTIVE (V_ACTIVE)
    ) u_draw_bg (
        .clk     (clk),
        .arst_n  (arst_n),
        .vga_in  (vga_tim),
        .vga_out (vga_bg)
    );

    draw_player #(
        .ROM_BASE (0),
        .V_TOTAL  (V_ACTIVE + V_FP + V_SYNC + V_BP)
    ) u_draw_dog (
        .clk       (clk),
        .arst_n    (arst_n),
        .x_pos     (dog_x),
        .y_pos     (dog_y),
        .vga_in    (vga_bg),
        .vga_out   (vga_dog),
        .req       (dog_req),
        .req_valid (dog_req_valid),
        .req_ready (dog_req_ready),
        .rsp       (dog_rsp),
        .rsp_valid (dog_rsp_valid)
    );

    draw_player #(
        .ROM_BASE (vga_pkg::SPRITE_W * vga_pkg::SPRITE_H),
        .V_TOTAL  (V_ACTIVE + V_FP + V_SYNC + V_BP)
    ) u_draw_cat (
        .clk       (clk),
        .arst_n    (arst_n),
        .x_pos     (cat_x),
        .y_pos     (cat_y),
        .vga_in    (vga_dog),
        .vga_out   (vga_cat),
        .req       (cat_req),
        .req_valid (cat_req_valid),
        .req_ready (cat_req_ready),
        .rsp       (cat_rsp),
        .rsp_valid (cat_rsp_valid)
    );

    sprite_rom_arbiter u_sprite_rom_arbiter (
        .clk           (clk),
        .arst_n        (arst_n),
        .dog_req       (dog_req),
        .dog_req_valid (dog_req_valid),
        .dog_req_ready (dog_req_ready),
        .cat_req       (cat_req),
        .cat_req_valid (cat_req_valid),
        .cat_req_ready (cat_req_ready),
        .rom_req       (rom_req),
        .rom_req_valid (rom_req_valid),
        .rom_rsp       (rom_rsp),
        .rom_rsp_valid (rom_rsp_valid),
        .dog_rsp       (dog_rsp),
        .dog_rsp_valid (dog_rsp_valid),
        .cat_rsp       (cat_rsp),
        .cat_rsp_valid (cat_rsp_valid)
    );

    sprite_rom u_sprite_rom (
        .clk           (clk),
        .arst_n        (arst_n),
        .rom_req       (rom_req),
        .rom_req_valid (rom_req_valid),
        .rom_rsp       (rom_rsp),
        .rom_rsp_valid (rom_rsp_valid)
    );

endmodule

`default_nettype wire

/* tb_top_vga.sv */
// Directed testbench for the VGA display top level in a small video mode
// Compares every output pixel and the syncs with a reference model of the screen
`timescale 1ns/1ps
`default_nettype none

module tb_top_vga;

    localparam int H_ACTIVE = 80;
    localparam int H_FP     = 4;
    localparam int H_SYNC   = 8;
    localparam int H_BP     = 80;
    localparam int V_ACTIVE = 48;
    localparam int V_FP     = 2;
    localparam int V_SYNC   = 2;
    localparam int V_BP     = 4;
    localparam int H_TOTAL  = H_ACTIVE + H_FP + H_SYNC + H_BP;
    localparam int V_TOTAL  = V_ACTIVE + V_FP + V_SYNC + V_BP;
    localparam int TIMEOUT  = 2 * H_TOTAL * V_TOTAL;

    // Screen colours and sprite geometry
    localparam logic [11:0] SKY    = 12'h6AF;
    localparam logic [11:0] GROUND = 12'h462;
    localparam logic [11:0] CLEAR  = 12'hF0F;
    localparam int          SPR    = 32;
    localparam int          OFF    = 1000;

    logic        clk;
    logic        arst_n;
    logic [10:0] dog_x;
    logic [10:0] dog_y;
    logic [10:0] cat_x;
    logic [10:0] cat_y;
    logic        hs;
    logic        vs;
    logic [3:0]  r;
    logic [3:0]  g;
    logic [3:0]  b;

    int          errors;
    int unsigned seed;

    top_vga #(
        .H_ACTIVE (H_ACTIVE), .H_FP (H_FP), .H_SYNC (H_SYNC), .H_BP (H_BP),
        .V_ACTIVE (V_ACTIVE), .V_FP (V_FP), .V_SYNC (V_SYNC), .V_BP (V_BP)
    ) dut_i (
        .clk    (clk),
        .arst_n (arst_n),
        .dog_x  (dog_x),
        .dog_y  (dog_y),
        .cat_x  (cat_x),
        .cat_y  (cat_y),
        .hs     (hs),
        .vs     (vs),
        .r      (r),
        .g      (g),
        .b      (b)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic int unsigned next_rand();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed >> 8;
    endfunction

    // Image word built from address bits with blue as addr[10] then addr[10:8]
    function automatic logic [11:0] rom_pixel(input int addr);
        logic [10:0] a;
        a = addr[10:0];
        return {a[3:0], a[7:4], a[10], a[10:8]};
    endfunction

    function automatic logic [11:0] expected_rgb(input int x, input int y,
                                                 input int dx, input int dy,
                                                 input int cx, input int cy);
        logic [11:0] pix;
        logic [11:0] word;
        if (x >= H_ACTIVE || y >= V_ACTIVE)
            return 12'h000;
        pix = (y >= V_ACTIVE - 16) ? GROUND : SKY;
        if (x >= dx && x < dx + SPR && y >= dy && y < dy + SPR) begin
            word = rom_pixel((y - dy) * SPR + (x - dx));
            if (word != CLEAR)
                pix = word;
        end
        // Cat layer is drawn last
        if (x >= cx && x < cx + SPR && y >= cy && y < cy + SPR) begin
            word = rom_pixel(1024 + (y - cy) * SPR + (x - cx));
            if (word != CLEAR)
                pix = word;
        end
        return pix;
    endfunction

    task automatic wait_sync_fall(input bit use_vs, input string test, output bit ok);
        logic prev;
        logic cur;
        ok = 1'b0;
        prev = use_vs ? vs : hs;
        for (int n = 0; n < TIMEOUT; n++) begin
            @(negedge clk);
            cur = use_vs ? vs : hs;
            if (prev && !cur) begin
                ok = 1'b1;
                break;
            end
            prev = cur;
        end
        if (!ok) begin
            errors++;
            $display("%s: timed out waiting for %s to fall", test, use_vs ? "vs" : "hs");
        end
    endtask

    // Counts samples while the sync stays at one level
    task automatic count_level(input bit use_vs, input logic level, output int n);
        n = 0;
        while (((use_vs ? vs : hs) == level) && n < TIMEOUT) begin
            n++;
            @(negedge clk);
        end
    endtask

    task automatic check_count(input string test, input int exp, input int act);
        if (act != exp) begin
            errors++;
            $display("mismatch %s: expected %0d actual %0d", test, exp, act);
        end
    endtask

    task automatic test_sync_timing();
        bit ok;
        int low;
        int high;
        wait_sync_fall(1'b0, "sync_timing", ok);
        if (ok) begin
            count_level(1'b0, 1'b0, low);
            count_level(1'b0, 1'b1, high);
            check_count("hs_low", H_SYNC, low);
            check_count("hs_period", H_TOTAL, low + high);
        end
        wait_sync_fall(1'b1, "sync_timing", ok);
        if (ok) begin
            count_level(1'b1, 1'b0, low);
            check_count("vs_low", V_SYNC * H_TOTAL, low);
        end
    endtask

    // Sets positions in vertical blanking, then compares one whole frame
    task automatic check_frame(input string test, input int dx, input int dy,
                               input int cx, input int cy);
        bit          ok;
        int          x;
        int          y;
        logic [11:0] exp_rgb;
        logic        exp_hs;
        logic        exp_vs;
        wait_sync_fall(1'b1, test, ok);
        if (ok) begin
            dog_x = 11'(dx);
            dog_y = 11'(dy);
            cat_x = 11'(cx);
            cat_y = 11'(cy);
            // vs falls on the first pixel of the first sync line
            x = 0;
            y = V_ACTIVE + V_FP;
            for (int n = 0; n < H_TOTAL * V_TOTAL; n++) begin
                exp_rgb = expected_rgb(x, y, dx, dy, cx, cy);
                exp_hs  = !(x >= H_ACTIVE + H_FP && x < H_ACTIVE + H_FP + H_SYNC);
                exp_vs  = !(y >= V_ACTIVE + V_FP && y < V_ACTIVE + V_FP + V_SYNC);
                if ({r, g, b} !== exp_rgb) begin
                    errors++;
                    $display("mismatch %s at (%0d,%0d): expected %h actual %h",
                             test, x, y, exp_rgb, {r, g, b});
                end
                if (hs !== exp_hs || vs !== exp_vs) begin
                    errors++;
                    $display("mismatch %s syncs at (%0d,%0d): expected %b%b actual %b%b",
                             test, x, y, exp_hs, exp_vs, hs, vs);
                end
                @(negedge clk);
                x++;
                if (x == H_TOTAL) begin
                    x = 0;
                    y = (y == V_TOTAL - 1) ? 0 : y + 1;
                end
            end
        end
    endtask

    initial begin
        int dx;
        int dy;
        int cx;
        int cy;
        errors = 0;
        seed   = 32466;
        arst_n = 1'b0;
        dog_x  = 11'(OFF);
        dog_y  = 11'(OFF);
        cat_x  = 11'(OFF);
        cat_y  = 11'(OFF);
        repeat (4) @(negedge clk);
        if (hs !== 1'b1 || vs !== 1'b1 || {r, g, b} !== 12'h000) begin
            errors++;
            $display("mismatch reset: expected hs vs rgb 1 1 000 actual %b %b %h",
                     hs, vs, {r, g, b});
        end
        arst_n = 1'b1;

        test_sync_timing();
        check_frame("background", OFF, OFF, OFF, OFF);
        check_frame("dog_alone", 20, 10, OFF, OFF);
        // Rows overlap so both drawers fetch in the same blanking intervals
        check_frame("two_sprites", 4, 8, 44, 12);
        // Cat's see-through pixel (row 24, column 15) lands on the dog
        check_frame("overlap", 30, 10, 25, 0);
        for (int i = 0; i < 5; i++) begin
            dx = next_rand() % 96;
            dy = next_rand() % 56;
            cx = next_rand() % 96;
            cy = next_rand() % 56;
            check_frame("random", dx, dy, cx, cy);
        end

        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* top_vga.f */
vga_pkg.sv
vga_timing.sv
draw_bg.sv
sprite_rom.sv
sprite_rom_arbiter.sv
draw_player.sv
top_vga.sv
tb_top_vga.sv

/* Bender.yml */
package:
  name: top_vga

sources:
  - vga_pkg.sv
  - vga_timing.sv
  - draw_bg.sv
  - sprite_rom.sv
  - sprite_rom_arbiter.sv
  - draw_player.sv
  - top_vga.sv
  - target: test
    files:
      - tb_top_vga.sv
